/* project.f */
design/icache_pkg.sv
design/icache_tag_store.sv
design/icache_data_store.sv
design/icache_ctrl.sv
design/icache_top.sv
testbench/icache_properties.sv
testbench/icache_tb.sv

/* run.sh */
#!/usr/bin/env bash
# build the icache testbench with Verilator and run it
# the exit status of the simulation is the result
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f project.f --top-module icache_tb -Mdir obj_dir &&
./obj_dir/Vicache_tb || { echo "icache simulation failed"; exit 1; }

/* testbench/icache_tb.sv */
/*
 * icache testbench
 * clock, reset, line memory with random ack delay, reference model of
 * tags / valid / round robin, and directed fetch tests
 */
`timescale 1ns/1ps
`default_nettype none

module icache_tb import icache_pkg::*;;

  localparam int          CLK_PERIOD   = 20;
  localparam int          RESET_CYCLES = 3;
  localparam int          NUM_TESTS    = 5;
  localparam int          TEST_CYCLES  = 500;
  localparam logic [31:0] LCG_SEED     = 32'he4cb114e;

  logic               clk_i;
  logic               rst_ni;
  logic               flush_i;
  logic               req_i;
  logic [ADDR_W-1:0]  addr_i;
  logic               ready_o;
  logic               valid_o;
  logic [FETCH_W-1:0] data_o;
  logic               miss_o;
  logic               mem_req_o;
  logic [ADDR_W-1:0]  mem_addr_o;
  logic               mem_ack_i;
  logic               mem_rtrn_vld_i;
  line_u              mem_rtrn_data_i;

  // reference model state
  logic [TAG_W-1:0]   m_tag [NUM_WAYS][NUM_SETS];
  logic               m_vld [NUM_WAYS][NUM_SETS];
  logic               m_rr  [NUM_SETS];

  icache_top i_dut (.*);

  initial begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  //////////////////////////////////////////////////////////////////////////
  // lcg, memory contents and reference model
  //////////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] lcg_step(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // fetch word as a function of the word address
  function automatic logic [FETCH_W-1:0] mem_word(input logic [ADDR_W-1:0] addr);
    logic [ADDR_W-1:0] wa;
    wa = addr >> 2;
    return (wa * 32'h9e3779b1) ^ 32'h5a5a_0f0f;
  endfunction

  function automatic line_u build_line(input logic [ADDR_W-1:0] line_addr);
    line_u l;
    for (int w = 0; w < WORDS_PER_LINE; w++) begin
      l.word[w] = mem_word(line_addr + ADDR_W'(w * 4));
    end
    return l;
  endfunction

  // returns 1 on hit, installs the line on a miss
  function automatic logic model_access(input logic [ADDR_W-1:0] addr);
    logic [INDEX_W-1:0] idx;
    logic [TAG_W-1:0]   tag;
    int                 victim;
    idx    = addr[OFFSET_W+INDEX_W-1:OFFSET_W];
    tag    = addr[ADDR_W-1:OFFSET_W+INDEX_W];
    victim = -1;
    for (int w = 0; w < NUM_WAYS; w++) begin
      if (m_vld[w][idx] && m_tag[w][idx] == tag) return 1'b1;
    end
    // lowest invalid way first
    for (int w = NUM_WAYS - 1; w >= 0; w--) begin
      if (!m_vld[w][idx]) victim = w;
    end
    if (victim < 0) begin
      victim    = int'(m_rr[idx]);
      m_rr[idx] = !m_rr[idx];
    end
    m_vld[victim][idx] = 1'b1;
    m_tag[victim][idx] = tag;
    return 1'b0;
  endfunction

  task automatic model_flush();
    for (int w = 0; w < NUM_WAYS; w++) begin
      for (int s = 0; s < NUM_SETS; s++) begin
        m_vld[w][s] = 1'b0;
      end
    end
  endtask

  task automatic check_word(input logic [FETCH_W-1:0] got, input logic [FETCH_W-1:0] exp,
                            input string what);
    if (got !== exp) begin
      $display("error @%0t: %s got %h expected %h", $time, what, got, exp);
      $display("CHECKS FAILED");
      $fatal(1, "stopped at first mismatch");
    end
  endtask

  task automatic check_bit(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      $display("error @%0t: %s got %b expected %b", $time, what, got, exp);
      $display("CHECKS FAILED");
      $fatal(1, "stopped at first mismatch");
    end
  endtask

  task automatic wait_ready();
    while (!ready_o) @(negedge clk_i);
  endtask

  // line memory with random ack delay and one return at least a cycle after ack
  initial begin : mem_model
    logic [31:0]       seed;
    logic [ADDR_W-1:0] line_addr;
    seed            = LCG_SEED;
    mem_ack_i       = 1'b0;
    mem_rtrn_vld_i  = 1'b0;
    mem_rtrn_data_i = '0;
    forever begin
      @(negedge clk_i);
      if (mem_req_o) begin
        seed = lcg_step(seed);
        repeat (seed[31:30]) @(negedge clk_i);
        mem_ack_i = 1'b1;
        line_addr = mem_addr_o;
        @(negedge clk_i);
        mem_ack_i = 1'b0;
        seed      = lcg_step(seed);
        repeat (seed[31:30]) @(negedge clk_i);
        mem_rtrn_vld_i  = 1'b1;
        mem_rtrn_data_i = build_line(line_addr);
        @(negedge clk_i);
        mem_rtrn_vld_i  = 1'b0;
      end
    end
  end

  //////////////////////////////////////////////////////////////////////////
  // request stream driven on the falling edge and sampled a quarter later
  //////////////////////////////////////////////////////////////////////////

  task automatic run_stream(input logic [ADDR_W-1:0] addrs[$], output int cycles);
    int                issued;
    int                misses;
    logic              pend;
    logic              pend_hit;
    logic [ADDR_W-1:0] pend_addr;
    issued    = 0;
    misses    = 0;
    cycles    = 0;
    pend      = 1'b0;
    pend_hit  = 1'b0;
    pend_addr = '0;
    while (issued < addrs.size() || pend) begin
      @(negedge clk_i);
      req_i  = (issued < addrs.size());
      addr_i = req_i ? addrs[issued] : '0;
      #(CLK_PERIOD / 4);
      cycles++;
      if (miss_o) misses++;
      if (pend) begin
        // a hit answers in the cycle right after acceptance
        if (pend_hit) begin
          check_bit(mem_req_o, 1'b0, "refill request on a hit");
          check_bit(valid_o, 1'b1, "hit answer one cycle after acceptance");
        end
        if (valid_o) begin
          check_word(data_o, mem_word(pend_addr), "fetch data");
          check_bit(logic'(misses > 0), !pend_hit, "miss pulse against model");
          check_bit(logic'(misses > 1), 1'b0, "more than one miss pulse");
          pend   = 1'b0;
          misses = 0;
        end
      end else begin
        check_bit(valid_o, 1'b0, "answer without a request");
      end
      if (req_i && ready_o) begin
        pend      = 1'b1;
        pend_addr = addrs[issued];
        pend_hit  = model_access(pend_addr);
        issued++;
      end
    end
    @(negedge clk_i);
    req_i = 1'b0;
  endtask

  //////////////////////////////////////////////////////////////////////////
  // directed tests
  //////////////////////////////////////////////////////////////////////////

  task automatic cold_miss_then_hit();
    logic [ADDR_W-1:0] q[$];
    int                cyc;
    q = '{32'h0000_1234, 32'h0000_1234};
    run_stream(q, cyc);
  endtask

  task automatic line_words_back_to_back();
    logic [ADDR_W-1:0] q[$];
    int                cyc;
    q = '{32'h0000_3040};
    run_stream(q, cyc);
    q = '{32'h0000_3040, 32'h0000_3044, 32'h0000_3048, 32'h0000_304c};
    run_stream(q, cyc);
    check_bit(logic'(cyc == WORDS_PER_LINE + 1), 1'b1, "hits not one per cycle");
  endtask

  // three tags over the two ways of set 5
  task automatic round_robin_replacement();
    logic [ADDR_W-1:0] q[$];
    int                cyc;
    q = '{32'h150, 32'h250, 32'h350, 32'h350, 32'h150, 32'h250, 32'h150};
    run_stream(q, cyc);
  endtask

  task automatic flush_clears_lines();
    logic [ADDR_W-1:0] q[$];
    int                cyc;
    @(negedge clk_i);
    flush_i = 1'b1;
    @(negedge clk_i);
    flush_i = 1'b0;
    check_bit(ready_o, 1'b0, "ready during flush");
    wait_ready();
    model_flush();
    q = '{32'h0000_1234, 32'h0000_3044, 32'h150, 32'h250};
    run_stream(q, cyc);
  endtask

  // tags 0..3 over sets 0..3
  task automatic random_fetches();
    logic [ADDR_W-1:0] q[$];
    logic [31:0]       seed;
    int                cyc;
    seed = LCG_SEED;
    for (int i = 0; i < 40; i++) begin
      seed = lcg_step(seed);
      q.push_back({22'd0, seed[31:30], 2'b00, seed[27:26], seed[23:22], 2'b00});
    end
    run_stream(q, cyc);
  endtask

  initial begin
    rst_ni  = 1'b0;
    flush_i = 1'b0;
    req_i   = 1'b0;
    addr_i  = '0;
    model_flush();
    for (int s = 0; s < NUM_SETS; s++) begin
      m_rr[s] = 1'b0;
    end
    repeat (RESET_CYCLES) @(negedge clk_i);
    rst_ni = 1'b1;
    // start-up flush walk
    check_bit(ready_o, 1'b0, "ready during start-up flush");
    wait_ready();
    cold_miss_then_hit();
    line_words_back_to_back();
    round_robin_replacement();
    flush_clears_lines();
    random_fetches();
    $display("ALL CHECKS PASSED");
    $finish;
  end

  // watchdog sized from the per test cycle budget
  initial begin
    repeat (RESET_CYCLES + NUM_SETS + 1 + NUM_TESTS * TEST_CYCLES) @(posedge clk_i);
    $display("CHECKS FAILED");
    $fatal(1, "watchdog: tests did not complete within the cycle budget");
  end

endmodule

`default_nettype wire

/* testbench/icache_properties.sv */
/*
 * icache controller properties
 * refill request hold, one-hot compare result, answer vs refill request
 */
`timescale 1ns/1ps
`default_nettype none

module icache_properties import icache_pkg::*; (
  input logic                clk_i,
  input logic                rst_ni,
  input logic                rd_o,
  input logic [NUM_WAYS-1:0] hit_i,
  input logic                valid_o,
  input logic                mem_req_o,
  input logic [ADDR_W-1:0]   mem_addr_o,
  input logic                mem_ack_i
);

  // request stays up with the same line address until acked
  req_hold_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    mem_req_o && !mem_ack_i |=> mem_req_o && $stable(mem_addr_o))
    else $error("refill request dropped or line address moved before ack");

  // a line lives in one way only
  hit_onehot_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    rd_o |=> $onehot0(hit_i))
    else $error("tag compare hit in more than one way");

  // an answer never overlaps an open refill request
  valid_no_req_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(valid_o && mem_req_o))
    else $error("valid_o raised while a refill request is open");

endmodule

bind icache_ctrl icache_properties i_properties (
  .clk_i      ( clk_i      ),
  .rst_ni     ( rst_ni     ),
  .rd_o       ( rd_o       ),
  .hit_i      ( hit_i      ),
  .valid_o    ( valid_o    ),
  .mem_req_o  ( mem_req_o  ),
  .mem_addr_o ( mem_addr_o ),
  .mem_ack_i  ( mem_ack_i  )
);

`default_nettype wire

/* design/icache_top.sv */
/*
 * two-way set associative instruction cache, 16 sets of 16-byte lines
 * blocking, one outstanding line refill, round-robin replacement
 */
`timescale 1ns/1ps
`default_nettype none

module icache_top import icache_pkg::*; (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 flush_i,
  // fetch port
  input  logic                 req_i,
  input  logic [ADDR_W-1:0]    addr_i,
  output logic                 ready_o,
  output logic                 valid_o,
  output logic [FETCH_W-1:0]   data_o,
  // to performance counter
  output logic                 miss_o,
  // refill port
  output logic                 mem_req_o,
  output logic [ADDR_W-1:0]    mem_addr_o,
  input  logic                 mem_ack_i,
  input  logic                 mem_rtrn_vld_i,
  input  line_u                mem_rtrn_data_i
);

  // lookup wires
  logic                              rd;
  logic [INDEX_W-1:0]                rd_index;
  logic [TAG_W-1:0]                  cmp_tag;
  logic [WORD_SEL_W-1:0]             word_sel;
  logic [NUM_WAYS-1:0]               hit;
  logic [WAY_W-1:0]                  victim;
  logic [NUM_WAYS-1:0][FETCH_W-1:0]  way_word;
  // refill write wires
  logic                              wr;
  logic [INDEX_W-1:0]                wr_index;
  logic [WAY_W-1:0]                  wr_way;
  logic [TAG_W-1:0]                  wr_tag;
  line_u                             wr_line;
  // flush walk
  logic                              flush_req;
  logic                              flush_done;

  icache_tag_store i_tag_store (
    .clk_i        ( clk_i      ),
    .rst_ni       ( rst_ni     ),
    .rd_i         ( rd         ),
    .rd_index_i   ( rd_index   ),
    .cmp_tag_i    ( cmp_tag    ),
    .wr_i         ( wr         ),
    .wr_index_i   ( wr_index   ),
    .wr_way_i     ( wr_way     ),
    .wr_tag_i     ( wr_tag     ),
    .flush_req_i  ( flush_req  ),
    .hit_o        ( hit        ),
    .victim_o     ( victim     ),
    .flush_done_o ( flush_done )
  );

  icache_data_store i_data_store (
    .clk_i        ( clk_i      ),
    .rd_i         ( rd         ),
    .rd_index_i   ( rd_index   ),
    .word_sel_i   ( word_sel   ),
    .wr_i         ( wr         ),
    .wr_index_i   ( wr_index   ),
    .wr_way_i     ( wr_way     ),
    .wr_line_i    ( wr_line    ),
    .way_word_o   ( way_word   )
  );

  icache_ctrl i_ctrl (
    .clk_i           ( clk_i           ),
    .rst_ni          ( rst_ni          ),
    .flush_i         ( flush_i         ),
    .req_i           ( req_i           ),
    .addr_i          ( addr_i          ),
    .ready_o         ( ready_o         ),
    .valid_o         ( valid_o         ),
    .data_o          ( data_o          ),
    .miss_o          ( miss_o          ),
    .mem_req_o       ( mem_req_o       ),
    .mem_addr_o      ( mem_addr_o      ),
    .mem_ack_i       ( mem_ack_i       ),
    .mem_rtrn_vld_i  ( mem_rtrn_vld_i  ),
    .mem_rtrn_data_i ( mem_rtrn_data_i ),
    .rd_o            ( rd              ),
    .rd_index_o      ( rd_index        ),
    .cmp_tag_o       ( cmp_tag         ),
    .word_sel_o      ( word_sel        ),
    .hit_i           ( hit             ),
    .victim_i        ( victim          ),
    .way_word_i      ( way_word        ),
    .wr_o            ( wr              ),
    .wr_index_o      ( wr_index        ),
    .wr_way_o        ( wr_way          ),
    .wr_tag_o        ( wr_tag          ),
    .wr_line_o       ( wr_line         ),
    .flush_req_o     ( flush_req       ),
    .flush_done_i    ( flush_done      )
  );

endmodule

`default_nettype wire

/* design/icache_ctrl.sv */
/*
 * icache controller
 * flush / idle / read / miss fsm, request address latch, hit data
 * mux, line refill request and the write of the returned line
 */
`timescale 1ns/1ps
`default_nettype none

module icache_ctrl import icache_pkg::*; (
  input  logic                              clk_i,
  input  logic                              rst_ni,
  // fetch side
  input  logic                              flush_i,
  input  logic                              req_i,
  input  logic [ADDR_W-1:0]                 addr_i,
  output logic                              ready_o,
  output logic                              valid_o,
  output logic [FETCH_W-1:0]                data_o,
  output logic                              miss_o,
  // refill port
  output logic                              mem_req_o,
  output logic [ADDR_W-1:0]                 mem_addr_o,
  input  logic                              mem_ack_i,
  input  logic                              mem_rtrn_vld_i,
  input  line_u                             mem_rtrn_data_i,
  // store read side
  output logic                              rd_o,
  output logic [INDEX_W-1:0]                rd_index_o,
  output logic [TAG_W-1:0]                  cmp_tag_o,
  output logic [WORD_SEL_W-1:0]             word_sel_o,
  input  logic [NUM_WAYS-1:0]               hit_i,
  input  logic [WAY_W-1:0]                  victim_i,
  input  logic [NUM_WAYS-1:0][FETCH_W-1:0]  way_word_i,
  // store write side
  output logic                              wr_o,
  output logic [INDEX_W-1:0]                wr_index_o,
  output logic [WAY_W-1:0]                  wr_way_o,
  output logic [TAG_W-1:0]                  wr_tag_o,
  output line_u                             wr_line_o,
  // flush walk
  output logic                              flush_req_o,
  input  logic                              flush_done_i
);

  logic [STATE_W-1:0]  state_d, state_q;
  logic                flush_d, flush_q;
  // request in flight
  logic [ADDR_W-1:0]   addr_q;
  logic [WAY_W-1:0]    victim_q;
  logic [FETCH_W-1:0]  hit_word;

  //////////////////////////////////////////////////////////////////////////
  // address split
  //////////////////////////////////////////////////////////////////////////

  // lookup indexes the stores with the incoming address
  assign rd_index_o = addr_i[OFFSET_W+INDEX_W-1:OFFSET_W];
  assign word_sel_o = addr_i[OFFSET_W-1:OFFSET_W-WORD_SEL_W];

  // compare and refill use the latched address
  assign cmp_tag_o  = addr_q[ADDR_W-1:OFFSET_W+INDEX_W];
  assign wr_tag_o   = addr_q[ADDR_W-1:OFFSET_W+INDEX_W];
  assign wr_index_o = addr_q[OFFSET_W+INDEX_W-1:OFFSET_W];
  assign wr_way_o   = victim_q;
  assign wr_line_o  = mem_rtrn_data_i;

  // line address with the offset zeroed
  assign mem_addr_o = {addr_q[ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}};

  // or of the way words gated by their hit bits
  always_comb begin
    hit_word = '0;
    for (int w = 0; w < NUM_WAYS; w++) begin
      hit_word = hit_word | ({FETCH_W{hit_i[w]}} & way_word_i[w]);
    end
  end

  // miss answers straight from the returned line
  assign data_o = (state_q == ST_MISS) ?
                  mem_rtrn_data_i.word[addr_q[OFFSET_W-1:OFFSET_W-WORD_SEL_W]] : hit_word;

  //////////////////////////////////////////////////////////////////////////
  // fsm
  //////////////////////////////////////////////////////////////////////////

  always_comb begin
    state_d     = state_q;
    // remember flush pulses until served
    flush_d     = flush_q | flush_i;
    ready_o     = 1'b0;
    valid_o     = 1'b0;
    miss_o      = 1'b0;
    mem_req_o   = 1'b0;
    rd_o        = 1'b0;
    wr_o        = 1'b0;
    flush_req_o = 1'b0;

    case (state_q)
      // clear all valid bits one set per cycle
      ST_FLUSH: begin
        flush_req_o = 1'b1;
        // nothing can be cached during the walk
        flush_d     = 1'b0;
        if (flush_done_i) begin
          state_d = ST_IDLE;
        end
      end
      // wait for a request
      ST_IDLE: begin
        if (flush_d) begin
          state_d = ST_FLUSH;
        end else begin
          ready_o = 1'b1;
          if (req_i) begin
            rd_o    = 1'b1;
            state_d = ST_READ;
          end
        end
      end
      // store outputs are valid here and either hit or request a refill
      ST_READ: begin
        if (|hit_i) begin
          valid_o = 1'b1;
          if (flush_d) begin
            state_d = ST_FLUSH;
          end else begin
            // overlap the next lookup with this answer
            ready_o = 1'b1;
            rd_o    = req_i;
            state_d = req_i ? ST_READ : ST_IDLE;
          end
        end else begin
          // hold the request until acknowledged
          mem_req_o = 1'b1;
          if (mem_ack_i) begin
            miss_o  = 1'b1;
            state_d = ST_MISS;
          end
        end
      end
      // wait for the line and then answer and write it in the same cycle
      ST_MISS: begin
        if (mem_rtrn_vld_i) begin
          valid_o = 1'b1;
          wr_o    = 1'b1;
          state_d = flush_d ? ST_FLUSH : ST_IDLE;
        end
      end
      default: begin
        state_d = ST_FLUSH;
      end
    endcase
  end

  // start with a flush since the arrays are unknown after reset
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= ST_FLUSH;
      flush_q <= 1'b0;
    end else begin
      state_q <= state_d;
      flush_q <= flush_d;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rd_o) begin
      addr_q <= addr_i;
    end
    // victim is stable while the refill request waits
    if (miss_o) begin
      victim_q <= victim_i;
    end
  end

endmodule

`default_nettype wire

/* design/icache_data_store.sv */
/*
 * icache data store
 * one line array per way, written flat on refill; a lookup reads
 * the set from all ways and each way delivers the addressed word
 */
`timescale 1ns/1ps
`default_nettype none

module icache_data_store import icache_pkg::*; (
  input  logic                               clk_i,
  // lookup
  input  logic                               rd_i,
  input  logic [INDEX_W-1:0]                 rd_index_i,
  input  logic [WORD_SEL_W-1:0]              word_sel_i,
  // refill write
  input  logic                               wr_i,
  input  logic [INDEX_W-1:0]                 wr_index_i,
  input  logic [WAY_W-1:0]                   wr_way_i,
  input  line_u                              wr_line_i,
  // one fetch word per way
  output logic [NUM_WAYS-1:0][FETCH_W-1:0]   way_word_o
);

  // line storage
  line_u                  line_mem  [NUM_WAYS][NUM_SETS];

  // registered read port
  line_u                  rd_line_q [NUM_WAYS];
  logic [WORD_SEL_W-1:0]  word_sel_q;

  always_ff @(posedge clk_i) begin
    // only the victim way of the set is replaced
    if (wr_i) begin
      line_mem[wr_way_i][wr_index_i].flat <= wr_line_i.flat;
    end
    if (rd_i) begin
      for (int w = 0; w < NUM_WAYS; w++) begin
        rd_line_q[w] <= line_mem[w][rd_index_i];
      end
      // word number travels with the read
      word_sel_q <= word_sel_i;
    end
  end

  // word pick per way, the hit mux sits in the controller
  for (genvar w = 0; w < NUM_WAYS; w++) begin : gen_word
    assign way_word_o[w] = rd_line_q[w].word[word_sel_q];
  end

endmodule

`default_nettype wire

/* design/icache_tag_store.sv */
/*
 * icache tag store
 * tag and valid arrays per way, registered read with tag compare,
 * victim choice (first invalid way, else per-set round robin) and
 * the flush walk that clears one set per cycle
 */
`timescale 1ns/1ps
`default_nettype none

module icache_tag_store import icache_pkg::*; (
  input  logic                clk_i,
  input  logic                rst_ni,
  // lookup
  input  logic                rd_i,
  input  logic [INDEX_W-1:0]  rd_index_i,
  input  logic [TAG_W-1:0]    cmp_tag_i,
  // refill write
  input  logic                wr_i,
  input  logic [INDEX_W-1:0]  wr_index_i,
  input  logic [WAY_W-1:0]    wr_way_i,
  input  logic [TAG_W-1:0]    wr_tag_i,
  // flush walk
  input  logic                flush_req_i,
  // results
  output logic [NUM_WAYS-1:0] hit_o,
  output logic [WAY_W-1:0]    victim_o,
  output logic                flush_done_o
);

  // tag and valid arrays that the flush walk clears
  logic [TAG_W-1:0]     tag_mem   [NUM_WAYS][NUM_SETS];
  logic [NUM_WAYS-1:0]  valid_mem [NUM_SETS];

  // registered read port
  logic [TAG_W-1:0]     tag_rd_q  [NUM_WAYS];
  logic [NUM_WAYS-1:0]  vld_rd_q;
  logic [INDEX_W-1:0]   rd_index_q;

  // replacement and flush state
  logic [NUM_SETS-1:0]  rr_q;
  logic [INDEX_W-1:0]   flush_cnt_q;
  logic                 wr_set_full;
  logic [WAY_W-1:0]     inv_way;

  //////////////////////////////////////////////////////////////////////////
  // arrays and read register
  //////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    // flush takes priority over a refill write
    if (flush_req_i) begin
      valid_mem[flush_cnt_q] <= '0;
    end else if (wr_i) begin
      valid_mem[wr_index_i][wr_way_i] <= 1'b1;
      tag_mem[wr_way_i][wr_index_i]   <= wr_tag_i;
    end
    // all ways of the set are read in parallel
    if (rd_i) begin
      for (int w = 0; w < NUM_WAYS; w++) begin
        tag_rd_q[w] <= tag_mem[w][rd_index_i];
      end
      vld_rd_q   <= valid_mem[rd_index_i];
      rd_index_q <= rd_index_i;
    end
  end

  // compare against the tag of the request in flight
  for (genvar w = 0; w < NUM_WAYS; w++) begin : gen_cmp
    assign hit_o[w] = vld_rd_q[w] & (tag_rd_q[w] == cmp_tag_i);
  end

  //////////////////////////////////////////////////////////////////////////
  // victim choice
  //////////////////////////////////////////////////////////////////////////

  // lowest invalid way of the set just read
  always_comb begin
    inv_way = '0;
    for (int w = NUM_WAYS - 1; w >= 0; w--) begin
      if (!vld_rd_q[w]) begin
        inv_way = WAY_W'(w);
      end
    end
  end

  // round robin only once every way holds a line
  assign victim_o = (&vld_rd_q) ? WAY_W'(rr_q[rd_index_q]) : inv_way;

  // eviction of a valid line advances that set's pointer
  assign wr_set_full = &valid_mem[wr_index_i];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rr_q        <= '0;
      flush_cnt_q <= '0;
    end else begin
      if (wr_i && wr_set_full) begin
        rr_q[wr_index_i] <= ~rr_q[wr_index_i];
      end
      // counter wraps to zero after the last set
      if (flush_req_i) begin
        flush_cnt_q <= flush_cnt_q + 1'b1;
      end
    end
  end

  // last set is being cleared in this cycle
  assign flush_done_o = flush_req_i & (flush_cnt_q == INDEX_W'(NUM_SETS - 1));

endmodule

`default_nettype wire

/* design/icache_pkg.sv */
/*
 * instruction cache package
 * cache geometry, fsm state codes and the line type shared by the
 * tag store, data store and controller of the two-way icache
 */
`default_nettype none

package icache_pkg;

  // fetch interface widths
  localparam int ADDR_W         = 32;
  localparam int FETCH_W        = 32;

  // associativity
  localparam int NUM_WAYS       = 2;
  localparam int WAY_W          = 1;

  // sets and line geometry
  localparam int NUM_SETS       = 16;
  localparam int INDEX_W        = 4;
  localparam int OFFSET_W       = 4;
  localparam int WORDS_PER_LINE = 4;
  localparam int WORD_SEL_W     = 2;
  localparam int LINE_W         = WORDS_PER_LINE * FETCH_W;
  // tag is everything above index and offset
  localparam int TAG_W          = ADDR_W - INDEX_W - OFFSET_W;

  // controller fsm encoding
  localparam int STATE_W                = 2;
  localparam logic [STATE_W-1:0] ST_FLUSH = 2'd0;
  localparam logic [STATE_W-1:0] ST_IDLE  = 2'd1;
  localparam logic [STATE_W-1:0] ST_READ  = 2'd2;
  localparam logic [STATE_W-1:0] ST_MISS  = 2'd3;

  // one cache line, written flat on refill and read by fetch word
  // word 0 sits in the low bits
  typedef union packed {
    logic [LINE_W-1:0]                       flat;
    logic [WORDS_PER_LINE-1:0][FETCH_W-1:0]  word;
  } line_u;

endpackage

`default_nettype wire
